// File: source/cpuCore_defs.svh
`ifndef CPU_CORE_DEFS_SVH
`define CPU_CORE_DEFS_SVH

// Data path and address width
`define WORD_BITS 32

// One byte per register field in the instruction word
`define REG_FIELD_BITS 8

// General purpose registers, addressed by field modulo count
`define GEN_REG_COUNT 64

// Fields at or above this value select a fixed register
`define FIXED_REG_BASE 64

// Fixed register fields
`define SP_FIELD 64
`define FLAGS_FIELD 65

// Size of the opcode word, the optional data word follows it
`define INSTR_BYTES 4

// Bytes moved per push or pop
`define STACK_STEP 4

`endif

// File: source/cpuPkg.sv
`include "cpuCore_defs.svh"

package cpuPkg;

  typedef logic [`WORD_BITS-1:0] dataWord;       // Register values, addresses, RAM data
  typedef logic [`REG_FIELD_BITS-1:0] regField;  // Register field taken from the instruction
  typedef logic [2:0] flagBits;                  // Bit 0 equal, bit 1 less, bit 2 greater

  // Byte 0 of every instruction word
  typedef enum logic [7:0] {
    MovRC   = 8'h01,  // r1 = const
    MovRR   = 8'h02,  // r1 = r2
    AddRRR  = 8'h03,  // r1 = r2 + r3
    AddRRC  = 8'h04,  // r1 = r2 + const
    SubRRR  = 8'h05,  // r1 = r2 - r3
    SubRRC  = 8'h06,  // r1 = r2 - const
    IncR    = 8'h07,
    DecR    = 8'h08,
    ShlRRR  = 8'h09,  // r1 = r2 << r3
    ShrRRR  = 8'h0a,  // Logical shift
    NegRR   = 8'h0b,  // r1 = -r2
    MovRdC  = 8'h10,  // r1 = [const]
    MovRdRo = 8'h11,  // r1 = [r2 + const]
    MovRdR  = 8'h12,  // r1 = [r2]
    MovdCR  = 8'h13,  // [const] = r2
    MovdRoR = 8'h14,  // [r1 + const] = r2
    PushR   = 8'h18,
    PopR    = 8'h19,
    CallR   = 8'h1a,  // Pushes own address, jumps to r1
    Ret     = 8'h1b,  // Resumes after the call
    CmpRR   = 8'h20,
    CmpRC   = 8'h21,
    JmpC    = 8'h28,
    JeC     = 8'h29,  // Taken on equal flag
    JneC    = 8'h2a,
    JzRC    = 8'h2b,  // Taken when r1 is zero
    JnzRC   = 8'h2c,
    DoutR   = 8'h30   // Debug output of r1
  } opCode;

  // Multicycle sequencer steps
  typedef enum logic [2:0] {
    FetchReq,
    FetchWait,
    Decode,
    DataWait,   // Second instruction word
    MemReq,
    MemWait,
    Process
  } seqState;

endpackage

// File: source/regPortIf.sv
`timescale 1ns/10ps

interface regPortIf import cpuPkg::*; ();

  regField readField1;    // Three combinational read ports
  regField readField2;
  regField readField3;
  dataWord readValue1;
  dataWord readValue2;
  dataWord readValue3;
  logic    writeEnable;   // General write, any field
  regField writeField;
  dataWord writeData;
  logic    spWrite;       // Dedicated stack pointer update
  dataWord spNext;
  logic    flagsWrite;    // Compare result
  flagBits flagsNext;
  dataWord stackPointer;
  flagBits flags;

  modport sequencer (
    output readField1, readField2, readField3, writeEnable, writeField, writeData,
           spWrite, spNext, flagsWrite, flagsNext,
    input  readValue1, readValue2, readValue3, stackPointer, flags
  );

  modport regFile (
    input  readField1, readField2, readField3, writeEnable, writeField, writeData,
           spWrite, spNext, flagsWrite, flagsNext,
    output readValue1, readValue2, readValue3, stackPointer, flags
  );

endinterface

// File: source/execIf.sv
`timescale 1ns/10ps

interface execIf import cpuPkg::*; ();

  opCode           op;             // Latched opcode
  cpuPkg::dataWord operandA;       // Value of field 1
  cpuPkg::dataWord operandB;       // Value of field 2
  cpuPkg::dataWord operandC;       // Value of field 3
  cpuPkg::dataWord dataWord;       // Constant or address word
  cpuPkg::dataWord ipointer;       // Address of the current instruction
  cpuPkg::dataWord loadValue;      // RAM read result
  cpuPkg::dataWord stackPointer;
  flagBits         flags;

  logic            needsDataWord;  // 8-byte instruction
  logic            isLoad;
  logic            isStore;
  logic            writesReg;      // Result goes to field 1
  cpuPkg::dataWord result;
  cpuPkg::dataWord memAddress;
  cpuPkg::dataWord storeValue;
  cpuPkg::dataWord nextIp;
  logic            spChange;
  cpuPkg::dataWord spNext;
  logic            flagsChange;
  flagBits         flagsNext;

  modport sequencer (
    output op, operandA, operandB, operandC, dataWord, ipointer, loadValue,
           stackPointer, flags,
    input  needsDataWord, isLoad, isStore, writesReg, result, memAddress, storeValue,
           nextIp, spChange, spNext, flagsChange, flagsNext
  );

  modport execute (
    input  op, operandA, operandB, operandC, dataWord, ipointer, loadValue,
           stackPointer, flags,
    output needsDataWord, isLoad, isStore, writesReg, result, memAddress, storeValue,
           nextIp, spChange, spNext, flagsChange, flagsNext
  );

endinterface

// File: source/registerFile.sv
`timescale 1ns/10ps
`include "cpuCore_defs.svh"

module registerFile import cpuPkg::*; (
  input logic       clk,
  input logic       reset,
  regPortIf.regFile regs
);

  localparam int GEN_INDEX_BITS = $clog2(`GEN_REG_COUNT);

  dataWord genRegs [`GEN_REG_COUNT];
  dataWord stackPointer;
  flagBits flags;

  // Field to value mapping, fixed registers sit above the general ones
  function automatic dataWord readReg(regField field);
    dataWord value;
    if (field >= `FIXED_REG_BASE) begin
      if (field == `SP_FIELD)
        value = stackPointer;
      else if (field == `FLAGS_FIELD)
        value = dataWord'(flags);
      else
        value = '0;  // Unused fixed slot
    end else begin
      value = genRegs[field[GEN_INDEX_BITS-1:0]];  // Field modulo count
    end
    return value;
  endfunction

  always_comb begin
    regs.readValue1 = readReg(regs.readField1);
    regs.readValue2 = readReg(regs.readField2);
    regs.readValue3 = readReg(regs.readField3);
  end

  assign regs.stackPointer = stackPointer;
  assign regs.flags        = flags;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      foreach (genRegs[i])
        genRegs[i] <= '0;
      stackPointer <= '0;
      flags        <= '0;
    end else begin
      if (regs.spWrite)
        stackPointer <= regs.spNext;      // Push, pop, call, ret
      if (regs.flagsWrite)
        flags <= regs.flagsNext;
      // General write, wins over the dedicated update on the same register
      if (regs.writeEnable) begin
        if (regs.writeField == `SP_FIELD)
          stackPointer <= regs.writeData;
        else if (regs.writeField == `FLAGS_FIELD)
          flags <= regs.writeData[$bits(flagBits)-1:0];
        else if (regs.writeField < `FIXED_REG_BASE)
          genRegs[regs.writeField[GEN_INDEX_BITS-1:0]] <= regs.writeData;
      end
    end
  end

endmodule

// File: source/executeUnit.sv
`timescale 1ns/10ps
`include "cpuCore_defs.svh"

module executeUnit import cpuPkg::*; (
  execIf.execute ex
);

  dataWord compareValue;  // Right side of a compare
  dataWord stepIp;        // Fall-through address

  // Opcode classification
  always_comb begin
    ex.needsDataWord = 1'b0;
    ex.isLoad        = 1'b0;
    ex.isStore       = 1'b0;
    case (ex.op)
      MovRC, AddRRC, SubRRC, CmpRC, JmpC, JeC, JneC, JzRC, JnzRC:
        ex.needsDataWord = 1'b1;
      MovRdC, MovRdRo: begin
        ex.needsDataWord = 1'b1;
        ex.isLoad        = 1'b1;
      end
      MovdCR, MovdRoR: begin
        ex.needsDataWord = 1'b1;
        ex.isStore       = 1'b1;
      end
      MovRdR, PopR, Ret:
        ex.isLoad = 1'b1;
      PushR, CallR:
        ex.isStore = 1'b1;
      default: ;  // Unknown opcode runs as a 4-byte no-op
    endcase
  end

  // ALU and register write-back selection
  always_comb begin
    ex.result    = ex.operandB;
    ex.writesReg = 1'b1;
    case (ex.op)
      MovRC:  ex.result = ex.dataWord;
      MovRR:  ex.result = ex.operandB;
      AddRRR: ex.result = ex.operandB + ex.operandC;
      AddRRC: ex.result = ex.operandB + ex.dataWord;
      SubRRR: ex.result = ex.operandB - ex.operandC;
      SubRRC: ex.result = ex.operandB - ex.dataWord;
      IncR:   ex.result = ex.operandA + 1'b1;
      DecR:   ex.result = ex.operandA - 1'b1;
      ShlRRR: ex.result = ex.operandB << ex.operandC;
      ShrRRR: ex.result = ex.operandB >> ex.operandC;
      NegRR:  ex.result = -ex.operandB;
      MovRdC, MovRdRo, MovRdR, PopR:
        ex.result = ex.loadValue;   // RAM word into field 1
      default:
        ex.writesReg = 1'b0;
    endcase
  end

  // RAM address and store data
  always_comb begin
    case (ex.op)
      MovRdRo: ex.memAddress = ex.operandB + ex.dataWord;
      MovdRoR: ex.memAddress = ex.operandA + ex.dataWord;
      MovRdR:  ex.memAddress = ex.operandB;
      PushR, CallR:
        ex.memAddress = ex.stackPointer;                // Stack grows upward
      PopR, Ret:
        ex.memAddress = ex.stackPointer - `STACK_STEP;  // Top entry
      default:
        ex.memAddress = ex.dataWord;                    // MovRdC, MovdCR
    endcase
    if (ex.op == CallR)
      ex.storeValue = ex.ipointer;  // Return address
    else if (ex.op == MovdCR || ex.op == MovdRoR)
      ex.storeValue = ex.operandB;
    else
      ex.storeValue = ex.operandA;
  end

  // Stack pointer
  always_comb begin
    ex.spChange = 1'b1;
    case (ex.op)
      PushR, CallR: ex.spNext = ex.stackPointer + `STACK_STEP;
      PopR, Ret:    ex.spNext = ex.stackPointer - `STACK_STEP;
      default: begin
        ex.spNext   = ex.stackPointer;
        ex.spChange = 1'b0;
      end
    endcase
  end

  // Unsigned compare into flags
  assign compareValue   = (ex.op == CmpRC) ? ex.dataWord : ex.operandB;
  assign ex.flagsChange = (ex.op == CmpRR) || (ex.op == CmpRC);
  assign ex.flagsNext   = {ex.operandA > compareValue,
                           ex.operandA < compareValue,
                           ex.operandA == compareValue};

  assign stepIp = ex.needsDataWord ? ex.ipointer + 2 * `INSTR_BYTES
                                   : ex.ipointer + `INSTR_BYTES;

  always_comb begin
    case (ex.op)
      JmpC:  ex.nextIp = ex.dataWord;
      JeC:   ex.nextIp = ex.flags[0] ? ex.dataWord : stepIp;   // Equal flag
      JneC:  ex.nextIp = ex.flags[0] ? stepIp : ex.dataWord;
      JzRC:  ex.nextIp = (ex.operandA == '0) ? ex.dataWord : stepIp;
      JnzRC: ex.nextIp = (ex.operandA != '0) ? ex.dataWord : stepIp;
      CallR: ex.nextIp = ex.operandA;
      Ret:   ex.nextIp = ex.loadValue + `INSTR_BYTES;  // Skip the call itself
      default:
        ex.nextIp = stepIp;
    endcase
  end

endmodule

// File: source/instrSequencer.sv
`timescale 1ns/10ps
`include "cpuCore_defs.svh"

module instrSequencer import cpuPkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  dataWord     ramIn,
  input  logic        ramReady,
  output dataWord     ramAddress,
  output dataWord     ramOut,
  output logic        readReq,
  output logic        writeReq,
  output dataWord     ipointer,
  output dataWord     debugValue,
  output logic        debugStrobe,
  regPortIf.sequencer regs,
  execIf.sequencer    ex
);

  seqState state;
  regField field1;     // Destination and first source
  regField field2;
  regField field3;
  logic    memAccess;  // Load or store pending
  logic    inProcess;

  assign memAccess = ex.isLoad || ex.isStore;
  assign inProcess = (state == Process);

  // Register reads follow the latched fields
  assign regs.readField1 = field1;
  assign regs.readField2 = field2;
  assign regs.readField3 = field3;

  // Write-back only in the last step
  assign regs.writeEnable = inProcess && ex.writesReg;
  assign regs.writeField  = field1;
  assign regs.writeData   = ex.result;
  assign regs.spWrite     = inProcess && ex.spChange;
  assign regs.spNext      = ex.spNext;
  assign regs.flagsWrite  = inProcess && ex.flagsChange;
  assign regs.flagsNext   = ex.flagsNext;

  assign ex.ipointer     = ipointer;
  assign ex.stackPointer = regs.stackPointer;
  assign ex.flags        = regs.flags;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state       <= FetchReq;
      readReq     <= 1'b0;
      writeReq    <= 1'b0;
      ramAddress  <= '0;
      ipointer    <= '0;
      debugValue  <= '0;
      debugStrobe <= 1'b0;
    end else begin
      debugStrobe <= 1'b0;  // Single cycle pulse
      case (state)
        FetchReq: begin
          readReq    <= 1'b1;
          ramAddress <= ipointer;
          state      <= FetchWait;
        end
        FetchWait: begin
          readReq <= 1'b0;
          if (ramReady)
            state <= Decode;
        end
        Decode: begin
          if (ex.needsDataWord) begin
            readReq    <= 1'b1;
            ramAddress <= ipointer + `INSTR_BYTES;  // Word after the opcode
            state      <= DataWait;
          end else if (memAccess) begin
            state <= MemReq;
          end else begin
            state <= Process;
          end
        end
        DataWait: begin
          readReq <= 1'b0;
          if (ramReady)
            state <= memAccess ? MemReq : Process;
        end
        MemReq: begin
          ramAddress <= ex.memAddress;
          readReq    <= ex.isLoad;
          writeReq   <= ex.isStore;
          state      <= MemWait;
        end
        MemWait: begin
          readReq  <= 1'b0;
          writeReq <= 1'b0;
          if (ramReady)
            state <= Process;
        end
        Process: begin
          ipointer <= ex.nextIp;
          if (ex.op == DoutR) begin
            debugValue  <= ex.operandA;
            debugStrobe <= 1'b1;
          end
          state <= FetchReq;
        end
        default:
          state <= FetchReq;
      endcase
    end
  end

  // Instruction, operand and RAM data latches
  always_ff @(posedge clk) begin
    if (state == FetchWait && ramReady) begin
      ex.op  <= opCode'(ramIn[`REG_FIELD_BITS-1:0]);
      field1 <= ramIn[2*`REG_FIELD_BITS-1:`REG_FIELD_BITS];
      field2 <= ramIn[3*`REG_FIELD_BITS-1:2*`REG_FIELD_BITS];
      field3 <= ramIn[4*`REG_FIELD_BITS-1:3*`REG_FIELD_BITS];
    end
    if (state == Decode) begin
      ex.operandA <= regs.readValue1;
      ex.operandB <= regs.readValue2;
      ex.operandC <= regs.readValue3;
    end
    if (state == DataWait && ramReady)
      ex.dataWord <= ramIn;     // Constant or address
    if (state == MemReq)
      ramOut <= ex.storeValue;  // Held until the memory answers
    if (state == MemWait && ramReady)
      ex.loadValue <= ramIn;
  end

endmodule

// File: source/cpuCore.sv
`timescale 1ns/10ps

module cpuCore import cpuPkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  dataWord ramIn,
  input  logic    ramReady,     // One cycle, read data valid with it
  output dataWord ramAddress,
  output dataWord ramOut,
  output logic    readReq,      // Single cycle request pulses
  output logic    writeReq,
  output dataWord ipointer,
  output dataWord debugValue,   // DoutR value
  output logic    debugStrobe
);

  regPortIf regPort ();
  execIf    execPort ();

  registerFile regFile (
    .clk   (clk),
    .reset (reset),
    .regs  (regPort.regFile)
  );

  executeUnit execUnit (
    .ex (execPort.execute)
  );

  // Owns the RAM port and the instruction pointer
  instrSequencer sequencer (
    .clk         (clk),
    .reset       (reset),
    .ramIn       (ramIn),
    .ramReady    (ramReady),
    .ramAddress  (ramAddress),
    .ramOut      (ramOut),
    .readReq     (readReq),
    .writeReq    (writeReq),
    .ipointer    (ipointer),
    .debugValue  (debugValue),
    .debugStrobe (debugStrobe),
    .regs        (regPort.sequencer),
    .ex          (execPort.sequencer)
  );

endmodule

// File: testbench/cpuCoreTb.sv
`timescale 1ns/10ps
`include "cpuCore_defs.svh"

module cpuCoreTb import cpuPkg::*; ();

  localparam int      RAM_WORDS      = 1024;
  localparam int      TIMEOUT_CYCLES = 2000;         // Per program run
  localparam dataWord SENTINEL       = 32'h5e17_0ded;
  localparam regField SENTINEL_REG   = 63;

  logic    clk = 1'b0;
  logic    reset = 1'b1;
  dataWord ramIn = '0;
  logic    ramReady = 1'b0;
  dataWord ramAddress;
  dataWord ramOut;
  logic    readReq;
  logic    writeReq;
  dataWord ipointer;
  dataWord debugValue;
  logic    debugStrobe;

  dataWord ram [RAM_WORDS];
  dataWord expectedOut[$];   // Predicted DoutR values
  dataWord seenOut[$];       // Values taken from debugStrobe
  dataWord progAddr;         // Assembler write pointer, byte address
  integer  seed = 3;
  logic    pending = 1'b0;   // Memory request in flight
  logic    reqRead;
  dataWord reqAddr;
  int      delayLeft;
  int      errors = 0;
  int      testsRun = 0;
  int      testsFailed = 0;

  cpuCore UUT (
    .clk(clk), .reset(reset), .ramIn(ramIn), .ramReady(ramReady),
    .ramAddress(ramAddress), .ramOut(ramOut), .readReq(readReq), .writeReq(writeReq),
    .ipointer(ipointer), .debugValue(debugValue), .debugStrobe(debugStrobe)
  );

  always #4 clk = ~clk;  // 8 ns period

  function automatic int ramIndex(dataWord address);
    return int'(address[11:2]);  // Word addressed
  endfunction

  // Behavioral RAM, answers 1 to 3 cycles after a request
  always begin
    @(posedge clk);
    #1;
    ramReady = 1'b0;
    if (reset) begin
      pending = 1'b0;
    end else begin
      if (pending) begin
        delayLeft--;
        if (delayLeft == 0) begin
          ramReady = 1'b1;
          if (reqRead)
            ramIn = ram[ramIndex(reqAddr)];  // Valid with ramReady
          pending = 1'b0;
        end
      end
      if (readReq || writeReq) begin
        reqAddr = ramAddress;
        reqRead = readReq;
        if (writeReq)
          ram[ramIndex(ramAddress)] = ramOut;
        delayLeft = 1 + $unsigned($random(seed)) % 3;
        pending   = 1'b1;
      end
    end
  end

  task automatic checkValue(input string name, input dataWord expectedValue,
                            input dataWord actualValue);
    assert (actualValue === expectedValue) else begin
      $display("ERR %s expected %h actual %h", name, expectedValue, actualValue);
      errors++;
    end
  endtask

  // Opcode byte 0xff everywhere, runs as a no-op
  task automatic clearProgram();
    for (int i = 0; i < RAM_WORDS; i++)
      ram[i] = {12'hfee, 2'b00, i[9:0], 8'hff};
    progAddr = '0;
    expectedOut.delete();
  endtask

  task automatic emit(input opCode op, input regField f1, input regField f2,
                      input regField f3);
    ram[ramIndex(progAddr)] = {f3, f2, f1, op};
    progAddr += `INSTR_BYTES;
  endtask

  task automatic emitConst(input opCode op, input regField f1, input regField f2,
                           input regField f3, input dataWord value);
    emit(op, f1, f2, f3);
    ram[ramIndex(progAddr)] = value;  // Data word after the opcode
    progAddr += `INSTR_BYTES;
  endtask

  // End marker, then a jump to itself
  task automatic emitSentinel();
    emitConst(MovRC, SENTINEL_REG, 0, 0, SENTINEL);
    emit(DoutR, SENTINEL_REG, 0, 0);
    emitConst(JmpC, 0, 0, 0, progAddr);
  endtask

  task automatic applyReset();
    @(posedge clk);
    #1;
    reset = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
  endtask

  // Gathers DoutR values until the sentinel, then compares with expectedOut
  task automatic runAndCompare();
    int  cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    seenOut.delete();
    while (!done && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      #1;
      cycles++;
      if (debugStrobe) begin
        if (debugValue == SENTINEL)
          done = 1'b1;
        else
          seenOut.push_back(debugValue);
      end
    end
    assert (done) else begin
      $display("Timed out waiting for the end marker on debugValue");
      errors++;
    end
    checkValue("debugStrobe count", expectedOut.size(), seenOut.size());
    for (int i = 0; i < expectedOut.size() && i < seenOut.size(); i++)
      checkValue($sformatf("debugValue[%0d]", i), expectedOut[i], seenOut[i]);
  endtask

  task automatic reportTest(input string name, input int errorsBefore);
    testsRun++;
    if (errors == errorsBefore) begin
      $display("%s: passed", name);
    end else begin
      testsFailed++;
      $display("%s: failed with %0d errors", name, errors - errorsBefore);
    end
  endtask

  // Flags rule: bit 0 equal, bit 1 less, bit 2 greater, unsigned
  function automatic flagBits compareFlags(dataWord a, dataWord b);
    flagBits f;
    f[0] = (a == b);
    f[1] = (a < b);
    f[2] = (a > b);
    return f;
  endfunction

  task automatic testResetState();
    int errorsBefore;
    int cycles;
    errorsBefore = errors;
    cycles       = 0;
    clearProgram();
    emitSentinel();
    applyReset();
    checkValue("ipointer", 32'h0, ipointer);  // Still in reset state
    checkValue("readReq", 32'h0, 32'(readReq));
    checkValue("writeReq", 32'h0, 32'(writeReq));
    checkValue("debugStrobe", 32'h0, 32'(debugStrobe));
    while (!readReq && cycles < 20) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    assert (readReq) else begin
      $display("No fetch request seen after reset");
      errors++;
    end
    checkValue("ramAddress", 32'h0, ramAddress);  // First fetch
    runAndCompare();
    reportTest("reset state", errorsBefore);
  endtask

  task automatic testArithmetic();
    int      errorsBefore;
    int      outRegs[10] = '{1, 4, 5, 6, 7, 8, 10, 11, 12, 13};
    dataWord a = 32'h7fff_fff0;
    dataWord b = 32'h0000_0025;
    dataWord sh = 32'd5;
    dataWord c1 = 32'h8000_0020;  // Forces a carry out
    dataWord c2 = 32'h0000_0030;  // Forces a borrow
    errorsBefore = errors;
    clearProgram();
    emitConst(MovRC, 1, 0, 0, a);
    emitConst(MovRC, 2, 0, 0, b);
    emitConst(MovRC, 3, 0, 0, sh);
    emit(AddRRR, 4, 1, 2);
    emitConst(AddRRC, 5, 1, 0, c1);
    emit(SubRRR, 6, 2, 1);
    emitConst(SubRRC, 7, 2, 0, c2);
    emit(MovRR, 8, 2, 0);
    emit(IncR, 8, 0, 0);
    emitConst(MovRC, 10, 0, 0, 32'h0);
    emit(DecR, 10, 0, 0);           // Wraps to all ones
    emit(ShlRRR, 11, 1, 3);
    emit(ShrRRR, 12, 1, 3);
    emit(NegRR, 13, 2, 0);
    foreach (outRegs[i])
      emit(DoutR, regField'(outRegs[i]), 0, 0);
    emitSentinel();
    expectedOut = '{a, a + b, a + c1, b - a, b - c2, b + 32'd1,
                    dataWord'(0) - dataWord'(1), a << sh, a >> sh, dataWord'(0) - b};
    applyReset();
    runAndCompare();
    reportTest("arithmetic", errorsBefore);
  endtask

  task automatic testLoadStore();
    int      errorsBefore;
    dataWord base = 32'h0000_0800;
    dataWord v1 = 32'h1234_5678;
    dataWord v2 = 32'h9abc_def0;
    errorsBefore = errors;
    clearProgram();
    emitConst(MovRC, 1, 0, 0, v1);
    emitConst(MovRC, 2, 0, 0, base);
    emitConst(MovRC, 3, 0, 0, v2);
    emitConst(MovdCR, 0, 1, 0, base);        // [base] = r1
    emitConst(MovdRoR, 2, 3, 0, 32'd8);      // [r2 + 8] = r3
    emitConst(MovRdC, 4, 0, 0, base);
    emitConst(MovRdRo, 5, 2, 0, 32'd8);
    emitConst(MovRC, 6, 0, 0, base + 32'd8);
    emit(MovRdR, 7, 6, 0);
    emit(DoutR, 4, 0, 0);
    emit(DoutR, 5, 0, 0);
    emit(DoutR, 7, 0, 0);
    emitSentinel();
    expectedOut = '{v1, v2, v2};
    applyReset();
    runAndCompare();
    checkValue("ram[base]", v1, ram[ramIndex(base)]);
    checkValue("ram[base+8]", v2, ram[ramIndex(base + 32'd8)]);
    reportTest("loads and stores", errorsBefore);
  endtask

  task automatic testStackCall();
    int      errorsBefore;
    dataWord stackBase = 32'h0000_0c00;
    dataWord subAddr = 32'h0000_0400;
    dataWord pushValue = 32'h1111_1111;
    dataWord callAddr;
    errorsBefore = errors;
    clearProgram();
    emitConst(MovRC, `SP_FIELD, 0, 0, stackBase);  // Stack away from code
    emitConst(MovRC, 1, 0, 0, pushValue);
    emit(PushR, 1, 0, 0);
    emitConst(MovRC, 1, 0, 0, 32'h2222_2222);     // Clobber the source
    emit(DoutR, `SP_FIELD, 0, 0);
    emit(PopR, 2, 0, 0);
    emit(DoutR, 2, 0, 0);
    emit(DoutR, `SP_FIELD, 0, 0);
    emitConst(MovRC, 3, 0, 0, subAddr);
    callAddr = progAddr;
    emit(CallR, 3, 0, 0);
    emitConst(MovRC, 4, 0, 0, 32'h33);             // Return lands here
    emit(DoutR, 4, 0, 0);
    emitSentinel();
    progAddr = subAddr;
    emitConst(MovRC, 5, 0, 0, 32'h44);
    emit(DoutR, 5, 0, 0);
    emit(DoutR, `SP_FIELD, 0, 0);
    emit(Ret, 0, 0, 0);
    expectedOut = '{stackBase + `STACK_STEP, pushValue, stackBase, 32'h44,
                    stackBase + `STACK_STEP, 32'h33};
    applyReset();
    runAndCompare();
    checkValue("ram[stack]", callAddr, ram[ramIndex(stackBase)]);  // Call's own address
    reportTest("stack, call and return", errorsBefore);
  endtask

  task automatic testCompareJump();
    int      errorsBefore;
    dataWord limit = 32'd5;
    dataWord count;
    dataWord loopAddr;
    flagBits f;
    errorsBefore = errors;
    clearProgram();
    emitConst(MovRC, 1, 0, 0, 32'd0);
    emitConst(MovRC, 2, 0, 0, limit);
    loopAddr = progAddr;
    emit(IncR, 1, 0, 0);
    emit(DoutR, 1, 0, 0);
    emitConst(CmpRC, 1, 0, 0, limit);
    emitConst(JneC, 0, 0, 0, loopAddr);
    emit(CmpRR, 1, 2, 0);
    emitConst(JeC, 0, 0, 0, progAddr + 32'd12);   // Skips one DoutR
    emit(DoutR, 2, 0, 0);
    emitConst(MovRC, 3, 0, 0, 32'd3);
    loopAddr = progAddr;
    emit(DoutR, 3, 0, 0);
    emit(DecR, 3, 0, 0);
    emitConst(JnzRC, 3, 0, 0, loopAddr);
    emitConst(JzRC, 3, 0, 0, progAddr + 32'd12);
    emit(DoutR, 2, 0, 0);
    emitConst(JmpC, 0, 0, 0, progAddr + 32'd12);
    emit(DoutR, 2, 0, 0);
    emitConst(CmpRC, 2, 0, 0, 32'd9);
    emitConst(JeC, 0, 0, 0, progAddr + 32'd12);   // Falls through on less
    emit(DoutR, 2, 0, 0);
    emit(DoutR, `FLAGS_FIELD, 0, 0);
    emitSentinel();
    // Expected trace from the flags rule
    count = 0;
    do begin
      count++;
      expectedOut.push_back(count);
      f = compareFlags(count, limit);
    end while (!f[0]);
    f = compareFlags(count, limit);
    if (!f[0])
      expectedOut.push_back(limit);
    for (int c = 3; c != 0; c--)
      expectedOut.push_back(dataWord'(c));
    f = compareFlags(limit, 32'd9);
    if (!f[0])
      expectedOut.push_back(limit);
    expectedOut.push_back(dataWord'(f));
    applyReset();
    runAndCompare();
    reportTest("compares and jumps", errorsBefore);
  endtask

  initial begin
    testResetState();
    testArithmetic();
    testLoadStore();
    testStackCall();
    testCompareJump();
    $display("Tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// File: cpuCore.f
+incdir+source
source/cpuPkg.sv
source/regPortIf.sv
source/execIf.sv
source/registerFile.sv
source/executeUnit.sv
source/instrSequencer.sv
source/cpuCore.sv
testbench/cpuCoreTb.sv

// File: Bender.yml
package:
  name: cpuCore

sources:
  - include_dirs:
      - source
    files:
      - source/cpuPkg.sv
      - source/regPortIf.sv
      - source/execIf.sv
      - source/registerFile.sv
      - source/executeUnit.sv
      - source/instrSequencer.sv
      - source/cpuCore.sv
  - target: test
    files:
      - testbench/cpuCoreTb.sv
